//--- hdl/radio_config.svh
// --------------------------------------------------------------------------
// Build constants for the single-channel radio block.
// Every window must be a power of two in size and aligned to its size.
// Register offsets are byte offsets inside their window.
// --------------------------------------------------------------------------
`ifndef RADIO_CONFIG_SVH
`define RADIO_CONFIG_SVH

// Sample format
`define RADIO_ITEM_W           32
`define RADIO_NIPC             2

// Register bus address map
`define RADIO_ADDR_W           20
`define RADIO_SHARED_BASE      20'h00000
`define RADIO_SHARED_SIZE      20'h00010
`define RADIO_CHAN_BASE        20'h01000
`define RADIO_CHAN_SIZE        20'h00080
`define RADIO_PERIPH_BASE      20'h80000
`define RADIO_PERIPH_SIZE      20'h80000

// Shared window, major version in the upper half
`define RADIO_REG_COMPAT       20'h00000
`define RADIO_COMPAT_NUM       32'h0001_0000

// Channel window
`define RADIO_REG_RX_CMD       20'h00000
`define RADIO_REG_RX_SPP       20'h00004
`define RADIO_REG_RX_STATUS    20'h00008
`define RADIO_REG_TX_UNDERRUNS 20'h0000C
`define RADIO_SPP_RESET        16'd8

`endif

//--- hdl/radio_pkg.sv
// --------------------------------------------------------------------------
// Types shared by the radio block. Widths come from the config header.
// --------------------------------------------------------------------------
`default_nettype none

`include "radio_config.svh"

package radio_pkg;

  // One radio clock worth of samples
  typedef logic [`RADIO_ITEM_W*`RADIO_NIPC-1:0] radio_word_t;

  typedef logic [`RADIO_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0]              reg_data_t;
  typedef logic [63:0]              radio_time_t;

  // Packet length in beats
  typedef logic [15:0] spp_t;

  // Value written to RX_CMD
  typedef enum logic [31:0] {
    RX_CMD_STOP = 32'd0,
    RX_CMD_CONT = 32'd1
  } rx_cmd_t;

  typedef enum logic {RX_IDLE, RX_RUN} rx_state_t;
  typedef enum logic {TX_IDLE, TX_RUN} tx_state_t;

endpackage

`default_nettype wire

//--- hdl/ctrl_addr_decoder.sv
// --------------------------------------------------------------------------
// Splits the register bus into shared, channel and peripheral windows.
// Windows are matched by mask, so they must be size aligned. Targets must
// return zero data when idle since all responses are ORed together.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "radio_config.svh"

module ctrl_addr_decoder import radio_pkg::*; (
  input  wire            radio_clk,
  input  wire            radio_rst,
  input  wire            ctrl_req_wr,
  input  wire            ctrl_req_rd,
  input  wire reg_addr_t ctrl_req_addr,
  input  wire reg_data_t ctrl_req_data,
  output logic           ctrl_resp_ack,
  output reg_data_t      ctrl_resp_data,
  output logic           chan_req_wr,
  output logic           chan_req_rd,
  output reg_addr_t      chan_req_addr,
  output reg_data_t      chan_req_data,
  input  wire            chan_resp_ack,
  input  wire reg_data_t chan_resp_data,
  output logic           periph_req_wr,
  output logic           periph_req_rd,
  output reg_addr_t      periph_req_addr,
  output reg_data_t      periph_req_data,
  input  wire            periph_resp_ack,
  input  wire reg_data_t periph_resp_data
);

  localparam reg_addr_t SHARED_MASK = ~(`RADIO_SHARED_SIZE - 20'd1);
  localparam reg_addr_t CHAN_MASK   = ~(`RADIO_CHAN_SIZE - 20'd1);
  localparam reg_addr_t PERIPH_MASK = ~(`RADIO_PERIPH_SIZE - 20'd1);

  logic      hit_shared;
  logic      hit_chan;
  logic      hit_periph;
  reg_addr_t shared_off;
  logic      local_ack;
  reg_data_t local_data;

  assign hit_shared = (ctrl_req_addr & SHARED_MASK) == `RADIO_SHARED_BASE;
  assign hit_chan   = (ctrl_req_addr & CHAN_MASK) == `RADIO_CHAN_BASE;
  assign hit_periph = (ctrl_req_addr & PERIPH_MASK) == `RADIO_PERIPH_BASE;
  assign shared_off = ctrl_req_addr & ~SHARED_MASK;

  // Channel window sees only its offset
  assign chan_req_wr   = ctrl_req_wr & hit_chan;
  assign chan_req_rd   = ctrl_req_rd & hit_chan;
  assign chan_req_addr = ctrl_req_addr & ~CHAN_MASK;
  assign chan_req_data = ctrl_req_data;

  // Peripheral keeps the full address
  assign periph_req_wr   = ctrl_req_wr & hit_periph;
  assign periph_req_rd   = ctrl_req_rd & hit_periph;
  assign periph_req_addr = ctrl_req_addr;
  assign periph_req_data = ctrl_req_data;

  // Shared registers and unmapped space answer here, one cycle later
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      local_ack  <= 1'b0;
      local_data <= '0;
    end else begin
      local_ack <= (ctrl_req_wr | ctrl_req_rd) & ~hit_chan & ~hit_periph;
      if (ctrl_req_rd && hit_shared && shared_off == `RADIO_REG_COMPAT) begin
        local_data <= `RADIO_COMPAT_NUM;
      end else begin
        local_data <= '0;
      end
    end
  end

  assign ctrl_resp_ack  = local_ack | chan_resp_ack | periph_resp_ack;
  assign ctrl_resp_data = local_data | chan_resp_data | periph_resp_data;

endmodule

`default_nettype wire

//--- hdl/radio_ctrl_regs.sv
// --------------------------------------------------------------------------
// Channel registers. Every request is acknowledged one cycle later; unused
// offsets read zero. Reading RX_STATUS clears the sticky overrun bit, and
// the underrun count wraps at 2^32.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "radio_config.svh"

module radio_ctrl_regs import radio_pkg::*; (
  input  wire            radio_clk,
  input  wire            radio_rst,
  input  wire            chan_req_wr,
  input  wire            chan_req_rd,
  input  wire reg_addr_t chan_req_addr,
  input  wire reg_data_t chan_req_data,
  output logic           chan_resp_ack,
  output reg_data_t      chan_resp_data,
  input  wire            rx_overrun,
  input  wire            tx_underrun,
  input  wire            radio_rx_running,
  output logic           rx_cmd_valid,
  output rx_cmd_t        rx_cmd,
  output spp_t           spp
);

  logic      overrun;
  reg_data_t underruns;
  reg_data_t rd_data;

  // Read mux
  always_comb begin
    case (chan_req_addr)
      `RADIO_REG_RX_SPP:       rd_data = {16'd0, spp};
      `RADIO_REG_RX_STATUS:    rd_data = {30'd0, overrun, radio_rx_running};
      `RADIO_REG_TX_UNDERRUNS: rd_data = underruns;
      default:                 rd_data = '0;
    endcase
  end

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      chan_resp_ack  <= 1'b0;
      chan_resp_data <= '0;
      rx_cmd_valid   <= 1'b0;
      spp            <= `RADIO_SPP_RESET;
      overrun        <= 1'b0;
      underruns      <= '0;
    end else begin
      chan_resp_ack  <= chan_req_wr | chan_req_rd;
      chan_resp_data <= chan_req_rd ? rd_data : '0;
      rx_cmd_valid   <= chan_req_wr && chan_req_addr == `RADIO_REG_RX_CMD;

      if (chan_req_wr && chan_req_addr == `RADIO_REG_RX_SPP) begin
        spp <= chan_req_data[15:0];
      end

      // A new overrun wins over a clearing read in the same cycle
      if (rx_overrun) begin
        overrun <= 1'b1;
      end else if (chan_req_rd && chan_req_addr == `RADIO_REG_RX_STATUS) begin
        overrun <= 1'b0;
      end

      if (tx_underrun) begin
        underruns <= underruns + 32'd1;
      end
    end
  end

  // Command word, qualified by rx_cmd_valid
  always_ff @(posedge radio_clk) begin
    if (chan_req_wr && chan_req_addr == `RADIO_REG_RX_CMD) begin
      rx_cmd <= rx_cmd_t'(chan_req_data);
    end
  end

endmodule

`default_nettype wire

//--- hdl/rx_framer.sv
// --------------------------------------------------------------------------
// Frames strobed radio samples into packets of spp beats. Only one beat is
// buffered; a strobe that finds it unaccepted is an overrun and ends the
// burst. An spp of zero gives 65536-beat packets.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rx_framer import radio_pkg::*; (
  input  wire              radio_clk,
  input  wire              radio_rst,
  input  wire              rx_cmd_valid,
  input  wire rx_cmd_t     rx_cmd,
  input  wire spp_t        spp,
  input  wire radio_time_t radio_time,
  input  wire radio_word_t radio_rx_data,
  input  wire              radio_rx_stb,
  input  wire              rx_tready,
  output radio_word_t      rx_tdata,
  output logic             rx_tlast,
  output logic             rx_tvalid,
  output radio_time_t      rx_ttimestamp,
  output logic             rx_teob,
  output logic             radio_rx_running,
  output logic             rx_overrun
);

  rx_state_t state;
  spp_t      beat_cnt;
  logic      pend_stop;
  logic      start;
  logic      stop_now;
  logic      ovf;
  logic      take;
  logic      pkt_end;

  assign start    = rx_cmd_valid && rx_cmd == RX_CMD_CONT;
  // Stop takes effect on the very next sample, even in the write cycle
  assign stop_now = pend_stop || (rx_cmd_valid && rx_cmd == RX_CMD_STOP);
  assign ovf      = radio_rx_stb && state == RX_RUN && rx_tvalid && !rx_tready;
  assign take     = radio_rx_stb && state == RX_RUN && !ovf;
  assign pkt_end  = beat_cnt == spp - 16'd1;

  assign radio_rx_running = state == RX_RUN;

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state      <= RX_IDLE;
      beat_cnt   <= '0;
      pend_stop  <= 1'b0;
      rx_tvalid  <= 1'b0;
      rx_overrun <= 1'b0;
    end else begin
      rx_overrun <= ovf;
      case (state)
        RX_IDLE: begin
          if (start) begin
            state     <= RX_RUN;
            beat_cnt  <= '0;
            pend_stop <= 1'b0;
          end
        end
        RX_RUN: begin
          if (ovf) begin
            state     <= RX_IDLE;
            pend_stop <= 1'b0;
          end else if (take) begin
            beat_cnt <= (pkt_end || stop_now) ? '0 : spp_t'(beat_cnt + 16'd1);
            if (stop_now) begin
              state     <= RX_IDLE;
              pend_stop <= 1'b0;
            end
          end else if (stop_now) begin
            pend_stop <= 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase

      // Output beat handshake
      if (take) begin
        rx_tvalid <= 1'b1;
      end else if (rx_tready) begin
        rx_tvalid <= 1'b0;
      end
    end
  end

  // Beat payload, timestamp latched on the first beat of each packet
  always_ff @(posedge radio_clk) begin
    if (take) begin
      rx_tdata <= radio_rx_data;
      rx_tlast <= pkt_end || stop_now;
      rx_teob  <= stop_now;
      if (beat_cnt == '0) begin
        rx_ttimestamp <= radio_time;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/tx_player.sv
// --------------------------------------------------------------------------
// Plays the Tx stream out one beat per radio strobe. A burst ends on its
// teob beat; tlast does not affect playback. A strobe with no beat while
// running sends zero and ends the burst as an underrun.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tx_player import radio_pkg::*; (
  input  wire              radio_clk,
  input  wire              radio_rst,
  input  wire radio_word_t tx_tdata,
  input  wire              tx_tlast,
  input  wire              tx_tvalid,
  input  wire              tx_teob,
  input  wire              radio_tx_stb,
  output logic             tx_tready,
  output radio_word_t      radio_tx_data,
  output logic             radio_tx_running,
  output logic             tx_underrun
);

  tx_state_t state;
  logic      accept;
  logic      starve;

  // The radio strobe paces the stream directly
  assign tx_tready = radio_tx_stb;
  assign accept    = radio_tx_stb && tx_tvalid;
  assign starve    = radio_tx_stb && !tx_tvalid && state == TX_RUN;

  assign radio_tx_running = state == TX_RUN;

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state       <= TX_IDLE;
      tx_underrun <= 1'b0;
    end else begin
      tx_underrun <= starve;
      if (accept) begin
        state <= tx_teob ? TX_IDLE : TX_RUN;
      end else if (starve) begin
        state <= TX_IDLE;
      end
    end
  end

  // Output sample, zero whenever nothing is being played
  always_ff @(posedge radio_clk) begin
    if (accept) begin
      radio_tx_data <= tx_tdata;
    end else if (radio_tx_stb || state == TX_IDLE) begin
      radio_tx_data <= '0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/radio_block.sv
// --------------------------------------------------------------------------
// Single-channel radio block on radio_clk. One register request may be
// outstanding at a time. Peripheral responses must drive zero data when
// they do not acknowledge.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module radio_block import radio_pkg::*; (
  input  wire              radio_clk,
  input  wire              radio_rst,
  // Register bus
  input  wire              ctrl_req_wr,
  input  wire              ctrl_req_rd,
  input  wire reg_addr_t   ctrl_req_addr,
  input  wire reg_data_t   ctrl_req_data,
  output logic             ctrl_resp_ack,
  output reg_data_t        ctrl_resp_data,
  // Peripheral window
  output logic             periph_req_wr,
  output logic             periph_req_rd,
  output reg_addr_t        periph_req_addr,
  output reg_data_t        periph_req_data,
  input  wire              periph_resp_ack,
  input  wire reg_data_t   periph_resp_data,
  // Radio side
  input  wire radio_time_t radio_time,
  input  wire radio_word_t radio_rx_data,
  input  wire              radio_rx_stb,
  output logic             radio_rx_running,
  output radio_word_t      radio_tx_data,
  input  wire              radio_tx_stb,
  output logic             radio_tx_running,
  // Rx stream
  output radio_word_t      rx_tdata,
  output logic             rx_tlast,
  output logic             rx_tvalid,
  input  wire              rx_tready,
  output radio_time_t      rx_ttimestamp,
  output logic             rx_teob,
  // Tx stream
  input  wire radio_word_t tx_tdata,
  input  wire              tx_tlast,
  input  wire              tx_tvalid,
  output logic             tx_tready,
  input  wire              tx_teob
);

  // Channel window
  logic      chan_req_wr;
  logic      chan_req_rd;
  reg_addr_t chan_req_addr;
  reg_data_t chan_req_data;
  logic      chan_resp_ack;
  reg_data_t chan_resp_data;

  // Register to datapath links
  logic      rx_cmd_valid;
  rx_cmd_t   rx_cmd;
  spp_t      spp;
  logic      rx_overrun;
  logic      tx_underrun;

  //--------------------------------------------------------------------------
  // Register access
  //--------------------------------------------------------------------------

  ctrl_addr_decoder ctrl_addr_decoder_i (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .ctrl_req_wr      (ctrl_req_wr),
    .ctrl_req_rd      (ctrl_req_rd),
    .ctrl_req_addr    (ctrl_req_addr),
    .ctrl_req_data    (ctrl_req_data),
    .ctrl_resp_ack    (ctrl_resp_ack),
    .ctrl_resp_data   (ctrl_resp_data),
    .chan_req_wr      (chan_req_wr),
    .chan_req_rd      (chan_req_rd),
    .chan_req_addr    (chan_req_addr),
    .chan_req_data    (chan_req_data),
    .chan_resp_ack    (chan_resp_ack),
    .chan_resp_data   (chan_resp_data),
    .periph_req_wr    (periph_req_wr),
    .periph_req_rd    (periph_req_rd),
    .periph_req_addr  (periph_req_addr),
    .periph_req_data  (periph_req_data),
    .periph_resp_ack  (periph_resp_ack),
    .periph_resp_data (periph_resp_data)
  );

  radio_ctrl_regs radio_ctrl_regs_i (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .chan_req_wr      (chan_req_wr),
    .chan_req_rd      (chan_req_rd),
    .chan_req_addr    (chan_req_addr),
    .chan_req_data    (chan_req_data),
    .chan_resp_ack    (chan_resp_ack),
    .chan_resp_data   (chan_resp_data),
    .rx_overrun       (rx_overrun),
    .tx_underrun      (tx_underrun),
    .radio_rx_running (radio_rx_running),
    .rx_cmd_valid     (rx_cmd_valid),
    .rx_cmd           (rx_cmd),
    .spp              (spp)
  );

  //--------------------------------------------------------------------------
  // Datapaths
  //--------------------------------------------------------------------------

  rx_framer rx_framer_i (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .rx_cmd_valid     (rx_cmd_valid),
    .rx_cmd           (rx_cmd),
    .spp              (spp),
    .radio_time       (radio_time),
    .radio_rx_data    (radio_rx_data),
    .radio_rx_stb     (radio_rx_stb),
    .rx_tready        (rx_tready),
    .rx_tdata         (rx_tdata),
    .rx_tlast         (rx_tlast),
    .rx_tvalid        (rx_tvalid),
    .rx_ttimestamp    (rx_ttimestamp),
    .rx_teob          (rx_teob),
    .radio_rx_running (radio_rx_running),
    .rx_overrun       (rx_overrun)
  );

  tx_player tx_player_i (
    .radio_clk        (radio_clk),
    .radio_rst        (radio_rst),
    .tx_tdata         (tx_tdata),
    .tx_tlast         (tx_tlast),
    .tx_tvalid        (tx_tvalid),
    .tx_teob          (tx_teob),
    .radio_tx_stb     (radio_tx_stb),
    .tx_tready        (tx_tready),
    .radio_tx_data    (radio_tx_data),
    .radio_tx_running (radio_tx_running),
    .tx_underrun      (tx_underrun)
  );

endmodule

`default_nettype wire

//--- tests/radio_block_props.sv
// --------------------------------------------------------------------------
// Bus and stream rules of the radio block, bound into every radio_block.
// Checked on radio_clk and ignored while radio_rst is high.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module radio_block_props import radio_pkg::*; (
  input wire              radio_clk,
  input wire              radio_rst,
  input wire              ctrl_resp_ack,
  input wire              periph_req_wr,
  input wire              periph_req_rd,
  input wire              rx_tvalid,
  input wire              rx_tready,
  input wire radio_word_t rx_tdata
);

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  // One request outstanding, so an ack is a single pulse
  ack_single_pulse: assert property (@(posedge radio_clk) disable iff (radio_rst)
    ctrl_resp_ack |=> !ctrl_resp_ack)
    else begin
      fail_count++;
      $error("ctrl_resp_ack was high two cycles running");
    end

  // Held Rx beat keeps its payload
  rx_beat_held: assert property (@(posedge radio_clk) disable iff (radio_rst)
    rx_tvalid && !rx_tready |=> $stable(rx_tdata))
    else begin
      fail_count++;
      $error("rx_tdata changed while the beat was stalled");
    end

  periph_one_strobe: assert property (@(posedge radio_clk) disable iff (radio_rst)
    !(periph_req_wr && periph_req_rd))
    else begin
      fail_count++;
      $error("periph_req_wr and periph_req_rd high together");
    end

endmodule

bind radio_block radio_block_props radio_block_props_i (
  .radio_clk     (radio_clk),
  .radio_rst     (radio_rst),
  .ctrl_resp_ack (ctrl_resp_ack),
  .periph_req_wr (periph_req_wr),
  .periph_req_rd (periph_req_rd),
  .rx_tvalid     (rx_tvalid),
  .rx_tready     (rx_tready),
  .rx_tdata      (rx_tdata)
);

`default_nettype wire

//--- tests/tb_radio_block.sv
// --------------------------------------------------------------------------
// Directed testbench for radio_block. Inputs change on the falling edge.
// The peripheral model answers after 1 to 5 cycles with address ^ 5A5A5A5A.
// The Rx sink can be held off through sink_hold, which acts one cycle late.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "radio_config.svh"

module tb_radio_block import radio_pkg::*; ();

  localparam int        CLK_PERIOD  = 40;
  // Rough cycle count of all tests together
  localparam int        TEST_CYCLES = 300;
  localparam reg_addr_t CHAN        = `RADIO_CHAN_BASE;

  logic        radio_clk;
  logic        radio_rst;
  logic        ctrl_req_wr;
  logic        ctrl_req_rd;
  reg_addr_t   ctrl_req_addr;
  reg_data_t   ctrl_req_data;
  logic        ctrl_resp_ack;
  reg_data_t   ctrl_resp_data;
  logic        periph_req_wr;
  logic        periph_req_rd;
  reg_addr_t   periph_req_addr;
  reg_data_t   periph_req_data;
  logic        periph_resp_ack;
  reg_data_t   periph_resp_data;
  radio_time_t radio_time;
  radio_word_t radio_rx_data;
  logic        radio_rx_stb;
  logic        radio_rx_running;
  radio_word_t radio_tx_data;
  logic        radio_tx_stb;
  logic        radio_tx_running;
  radio_word_t rx_tdata;
  logic        rx_tlast;
  logic        rx_tvalid;
  logic        rx_tready;
  radio_time_t rx_ttimestamp;
  logic        rx_teob;
  radio_word_t tx_tdata;
  logic        tx_tlast;
  logic        tx_tvalid;
  logic        tx_tready;
  logic        tx_teob;

  // Last request seen by the peripheral model
  logic        periph_seen_wr;
  reg_addr_t   periph_seen_addr;
  reg_data_t   periph_seen_data;

  // Rx sink records and expected samples
  logic        sink_hold;
  radio_word_t got_data[$];
  logic        got_last[$];
  logic        got_eob[$];
  radio_time_t got_ts[$];
  radio_word_t exp_rx_data[$];
  radio_time_t exp_rx_ts[$];

  radio_block radio_block_i (.*);

  initial begin
    radio_clk = 1'b0;
    forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
  end

  initial begin
    radio_time = '0;
    forever begin
      @(negedge radio_clk);
      radio_time = radio_time + 64'd1;
    end
  end

  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 4);
    report_failure("Watchdog expired before the tests finished");
  end

  //--------------------------------------------------------------------------
  // Peripheral responder and Rx sink
  //--------------------------------------------------------------------------

  initial begin : periph_model
    int unsigned delay;
    reg_addr_t   addr;
    logic        is_rd;
    periph_resp_ack  = 1'b0;
    periph_resp_data = '0;
    forever begin
      @(posedge radio_clk);
      if (periph_req_wr || periph_req_rd) begin
        addr             = periph_req_addr;
        is_rd            = periph_req_rd;
        periph_seen_wr   = periph_req_wr;
        periph_seen_addr = periph_req_addr;
        periph_seen_data = periph_req_data;
        delay            = 1 + ($urandom % 5);
        repeat (delay) @(negedge radio_clk);
        periph_resp_ack  <= 1'b1;
        periph_resp_data <= is_rd ? (reg_data_t'(addr) ^ 32'h5A5A_5A5A) : '0;
        @(negedge radio_clk);
        periph_resp_ack  <= 1'b0;
        periph_resp_data <= '0;
      end
    end
  end

  // A beat seen valid and ready here is taken at the next rising edge
  initial begin
    rx_tready = 1'b0;
    forever begin
      @(negedge radio_clk);
      rx_tready = !sink_hold;
      if (rx_tvalid && rx_tready) begin
        got_data.push_back(rx_tdata);
        got_last.push_back(rx_tlast);
        got_eob.push_back(rx_teob);
        got_ts.push_back(rx_ttimestamp);
      end
    end
  end

  //--------------------------------------------------------------------------
  // Compare and helper tasks
  //--------------------------------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input radio_word_t got, input radio_word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_time(input string name, input radio_time_t got, input radio_time_t exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Drops the strobe after one cycle and counts cycles up to the ack
  task automatic wait_ack(output reg_data_t data, output int lat);
    lat = 0;
    do begin
      @(negedge radio_clk);
      ctrl_req_wr = 1'b0;
      ctrl_req_rd = 1'b0;
      lat++;
      if (lat > 20) begin
        report_failure("No acknowledge on the register bus within 20 cycles");
      end
    end while (!ctrl_resp_ack);
    data = ctrl_resp_data;
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_data_t resp;
    int        lat;
    @(negedge radio_clk);
    ctrl_req_wr   = 1'b1;
    ctrl_req_addr = addr;
    ctrl_req_data = data;
    wait_ack(resp, lat);
    check_data("ctrl_resp_data on write", resp, '0);
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data, output int lat);
    @(negedge radio_clk);
    ctrl_req_rd   = 1'b1;
    ctrl_req_addr = addr;
    wait_ack(data, lat);
  endtask

  task automatic wait_rx_running(input logic level);
    int cycles;
    cycles = 0;
    while (radio_rx_running !== level) begin
      @(negedge radio_clk);
      cycles++;
      if (cycles > 20) begin
        report_failure("radio_rx_running did not reach the expected level");
      end
    end
  endtask

  task automatic wait_rx_beats(input int count);
    int cycles;
    cycles = 0;
    while (got_data.size() < count) begin
      @(negedge radio_clk);
      cycles++;
      if (cycles > 50) begin
        report_failure("Rx sink did not receive the expected beats in time");
      end
    end
  endtask

  // One-cycle radio strobe that notes the time the DUT samples with it
  task automatic strobe_rx_sample();
    radio_word_t sample;
    sample = {$urandom, $urandom};
    @(negedge radio_clk);
    radio_rx_stb  = 1'b1;
    radio_rx_data = sample;
    @(posedge radio_clk);
    exp_rx_data.push_back(sample);
    exp_rx_ts.push_back(radio_time);
    @(negedge radio_clk);
    radio_rx_stb = 1'b0;
    repeat ($urandom % 3) @(negedge radio_clk);
  endtask

  task automatic forget_rx_beats();
    got_data.delete();
    got_last.delete();
    got_eob.delete();
    got_ts.delete();
    exp_rx_data.delete();
    exp_rx_ts.delete();
  endtask

  task automatic play_tx_beat(input logic valid, input radio_word_t data, input logic eob);
    @(negedge radio_clk);
    radio_tx_stb = 1'b1;
    tx_tvalid    = valid;
    tx_tdata     = data;
    tx_teob      = eob;
    tx_tlast     = eob;
    @(posedge radio_clk);
    check_bit("tx_tready", tx_tready, 1'b1);
    @(negedge radio_clk);
    radio_tx_stb = 1'b0;
    tx_tvalid    = 1'b0;
    tx_teob      = 1'b0;
    tx_tlast     = 1'b0;
  endtask

  //--------------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------------

  task automatic shared_window_reads();
    reg_data_t data;
    int        lat;
    reg_read(`RADIO_SHARED_BASE + `RADIO_REG_COMPAT, data, lat);
    check_data("compat ctrl_resp_data", data, `RADIO_COMPAT_NUM);
    check_data("compat ctrl_resp_ack latency", reg_data_t'(lat), 32'd1);
    reg_read(20'h02000, data, lat);
    check_data("unmapped ctrl_resp_data", data, '0);
    check_data("unmapped ctrl_resp_ack latency", reg_data_t'(lat), 32'd1);
  endtask

  task automatic periph_window_access();
    reg_addr_t addr;
    reg_data_t wdata;
    reg_data_t data;
    int        lat;
    for (int i = 0; i < 3; i++) begin
      addr  = `RADIO_PERIPH_BASE | reg_addr_t'($urandom & 32'h7FFFC);
      wdata = $urandom;
      reg_write(addr, wdata);
      check_bit("periph_req_wr", periph_seen_wr, 1'b1);
      check_data("periph_req_addr", reg_data_t'(periph_seen_addr), reg_data_t'(addr));
      check_data("periph_req_data", periph_seen_data, wdata);
      reg_read(addr, data, lat);
      check_bit("periph_req_wr on read", periph_seen_wr, 1'b0);
      check_data("periph_req_addr", reg_data_t'(periph_seen_addr), reg_data_t'(addr));
      check_data("periph ctrl_resp_data", data, reg_data_t'(addr) ^ 32'h5A5A_5A5A);
    end
  endtask

  // Six beats at spp 4 and a stop that closes the burst on the seventh
  task automatic rx_burst_framing();
    reg_data_t data;
    int        lat;
    forget_rx_beats();
    reg_write(CHAN + `RADIO_REG_RX_SPP, 32'd4);
    reg_write(CHAN + `RADIO_REG_RX_CMD, reg_data_t'(RX_CMD_CONT));
    wait_rx_running(1'b1);
    for (int i = 0; i < 6; i++) begin
      strobe_rx_sample();
    end
    reg_write(CHAN + `RADIO_REG_RX_CMD, reg_data_t'(RX_CMD_STOP));
    strobe_rx_sample();
    wait_rx_running(1'b0);
    wait_rx_beats(7);
    for (int i = 0; i < 7; i++) begin
      check_word("rx_tdata", got_data[i], exp_rx_data[i]);
      check_bit("rx_tlast", got_last[i], (i % 4 == 3) || (i == 6));
      check_bit("rx_teob", got_eob[i], i == 6);
      check_time("rx_ttimestamp", got_ts[i], exp_rx_ts[(i / 4) * 4]);
    end
    reg_read(CHAN + `RADIO_REG_RX_STATUS, data, lat);
    check_data("RX_STATUS after stop", data, '0);
  endtask

  task automatic rx_overrun_flag();
    reg_data_t data;
    int        lat;
    forget_rx_beats();
    reg_write(CHAN + `RADIO_REG_RX_CMD, reg_data_t'(RX_CMD_CONT));
    wait_rx_running(1'b1);
    sink_hold <= 1'b1;
    repeat (2) @(negedge radio_clk);
    strobe_rx_sample();
    strobe_rx_sample();
    check_bit("radio_rx_running after overrun", radio_rx_running, 1'b0);
    reg_read(CHAN + `RADIO_REG_RX_STATUS, data, lat);
    check_data("RX_STATUS after overrun", data, 32'h2);
    reg_read(CHAN + `RADIO_REG_RX_STATUS, data, lat);
    check_data("RX_STATUS second read", data, 32'h0);
    sink_hold <= 1'b0;
    wait_rx_beats(1);
    check_word("held rx_tdata", got_data[0], exp_rx_data[0]);
    check_bit("held rx_teob", got_eob[0], 1'b0);
  endtask

  task automatic tx_burst_playback();
    radio_word_t sample;
    reg_data_t   data;
    int          lat;
    for (int i = 0; i < 4; i++) begin
      sample = {$urandom, $urandom};
      play_tx_beat(1'b1, sample, i == 3);
      check_word("radio_tx_data", radio_tx_data, sample);
      check_bit("radio_tx_running", radio_tx_running, i != 3);
    end
    @(negedge radio_clk);
    check_word("idle radio_tx_data", radio_tx_data, '0);
    check_bit("idle tx_tready", tx_tready, 1'b0);
    // Second burst starves after its first beat
    sample = {$urandom, $urandom};
    play_tx_beat(1'b1, sample, 1'b0);
    check_bit("radio_tx_running", radio_tx_running, 1'b1);
    play_tx_beat(1'b0, '0, 1'b0);
    check_word("underrun radio_tx_data", radio_tx_data, '0);
    check_bit("radio_tx_running after underrun", radio_tx_running, 1'b0);
    reg_read(CHAN + `RADIO_REG_TX_UNDERRUNS, data, lat);
    check_data("TX_UNDERRUNS", data, 32'd1);
  endtask

  initial begin
    void'($urandom(66));
    radio_rst     = 1'b1;
    ctrl_req_wr   = 1'b0;
    ctrl_req_rd   = 1'b0;
    ctrl_req_addr = '0;
    ctrl_req_data = '0;
    radio_rx_data = '0;
    radio_rx_stb  = 1'b0;
    radio_tx_stb  = 1'b0;
    tx_tdata      = '0;
    tx_tlast      = 1'b0;
    tx_tvalid     = 1'b0;
    tx_teob       = 1'b0;
    sink_hold     = 1'b0;
    repeat (3) @(negedge radio_clk);
    radio_rst = 1'b0;

    shared_window_reads();
    periph_window_access();
    rx_burst_framing();
    rx_overrun_flag();
    tx_burst_playback();

    if (radio_block_i.radio_block_props_i.fail_count != 0) begin
      report_failure("Bound assertions on radio_block failed");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- radio_block.f
+incdir+hdl
hdl/radio_pkg.sv
hdl/ctrl_addr_decoder.sv
hdl/radio_ctrl_regs.sv
hdl/rx_framer.sv
hdl/tx_player.sv
hdl/radio_block.sv
tests/radio_block_props.sv
tests/tb_radio_block.sv

//--- run_sim.sh
#!/bin/sh
# Build the radio block testbench with Verilator, run it, and look for the
# pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_radio_block -f radio_block.f -o tb_radio_block &&
./obj_dir/tb_radio_block | tee sim.log &&
grep -qF '*** PASSED ***' sim.log || {
  echo "Simulation did not pass, see sim.log"
  exit 1
}
